// ==== saturn_alu_pkg.sv ====
package saturn_alu_pkg;

  // widths fixed by the architecture
  localparam int NIB_W  = 4;
  localparam int WORD_W = 64;
  localparam int IDX_W  = 4;
  localparam int SEL_W  = 3;
  localparam int OP_W   = 2;

  // A, B, C and D
  localparam int NUM_WREGS = 4;

  // decimal digit radix, sized for the 5-bit carry sum
  localparam logic [NIB_W:0] DEC_RADIX = 5'd10;

  // one hex or bcd digit
  typedef logic [NIB_W-1:0] nibble_t;

  // full working register
  typedef logic [WORD_W-1:0] word_t;

  // nibble position inside a word, 0 is least significant
  typedef logic [IDX_W-1:0] nib_idx_t;

  // operand selector
  typedef logic [SEL_W-1:0] reg_sel_t;

  localparam reg_sel_t REG_A   = 3'd0;
  localparam reg_sel_t REG_B   = 3'd1;
  localparam reg_sel_t REG_C   = 3'd2;
  localparam reg_sel_t REG_D   = 3'd3;
  // immediate nibble, never written as a destination
  localparam reg_sel_t REG_IMM = 3'd4;

  // operation code
  typedef logic [OP_W-1:0] alu_op_t;

  localparam alu_op_t OP_ZERO = 2'd0;
  localparam alu_op_t OP_COPY = 2'd1;
  localparam alu_op_t OP_ADD  = 2'd2;
  localparam alu_op_t OP_SUB  = 2'd3;

  // field walk
  typedef enum logic [1:0] {
    SEQ_IDLE = 2'd0,
    SEQ_RUN  = 2'd1,
    SEQ_DONE = 2'd2
  } seq_state_t;

endpackage

// ==== alu_sequencer.sv ====
`timescale 1ns/100ps

module alu_sequencer
  import saturn_alu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_start,
  input  alu_op_t  i_op,
  input  reg_sel_t i_dest,
  input  reg_sel_t i_src1,
  input  reg_sel_t i_src2,
  input  nib_idx_t i_field_start,
  input  nib_idx_t i_field_last,
  input  nibble_t  i_imm,
  input  logic     i_dec,
  output logic     o_step,
  output logic     o_first,
  output nib_idx_t o_idx,
  output alu_op_t  o_op,
  output reg_sel_t o_dest,
  output reg_sel_t o_src1,
  output reg_sel_t o_src2,
  output nibble_t  o_imm,
  output logic     o_dec,
  output logic     o_busy,
  output logic     o_done
);

  seq_state_t state_q;
  nib_idx_t   idx_q;
  nib_idx_t   last_q;
  logic       first_q;
  logic       busy_q;
  logic       done_q;
  alu_op_t    op_q;
  reg_sel_t   dest_q;
  reg_sel_t   src1_q;
  reg_sel_t   src2_q;
  nibble_t    imm_q;
  logic       dec_q;
  logic       accept;

  // strobes during a walk or the done cycle are dropped
  assign accept = (state_q == SEQ_IDLE) && i_start && !done_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q <= SEQ_IDLE;
      first_q <= 1'b0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (accept) begin
            state_q <= SEQ_RUN;
            first_q <= 1'b1;
          end
        end
        SEQ_RUN: begin
          first_q <= 1'b0;
          if (idx_q == last_q) begin
            state_q <= SEQ_DONE;
          end
        end
        SEQ_DONE: begin
          state_q <= SEQ_IDLE;
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  // status trails the state by one cycle
  // busy covers the write edges and done follows the last carry update
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      busy_q <= (state_q == SEQ_RUN);
      done_q <= (state_q == SEQ_DONE);
    end
  end

  // instruction latch and a nibble walk that wraps modulo 16
  always_ff @(posedge i_clk) begin
    if (accept) begin
      idx_q  <= i_field_start;
      last_q <= i_field_last;
      op_q   <= i_op;
      dest_q <= i_dest;
      src1_q <= i_src1;
      src2_q <= i_src2;
      imm_q  <= i_imm;
      dec_q  <= i_dec;
    end else if (state_q == SEQ_RUN) begin
      idx_q <= idx_q + 4'd1;
    end
  end

  assign o_step  = (state_q == SEQ_RUN);
  assign o_first = first_q;
  assign o_idx   = idx_q;
  assign o_op    = op_q;
  assign o_dest  = dest_q;
  assign o_src1  = src1_q;
  assign o_src2  = src2_q;
  assign o_imm   = imm_q;
  assign o_dec   = dec_q;
  assign o_busy  = busy_q;
  assign o_done  = done_q;

endmodule

// ==== working_reg.sv ====
`timescale 1ns/100ps

module working_reg
  import saturn_alu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_we,
  input  nib_idx_t i_idx,
  input  nibble_t  i_wdata,
  output word_t    o_word
);

  word_t word_q;

  // only the addressed nibble moves, the rest of the word holds
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      word_q <= '0;
    end else if (i_we) begin
      word_q[{i_idx, 2'b00} +: NIB_W] <= i_wdata;
    end
  end

  assign o_word = word_q;

endmodule

// ==== nibble_datapath.sv ====
`timescale 1ns/100ps

module nibble_datapath
  import saturn_alu_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_step,
  input  logic                 i_first,
  input  nib_idx_t             i_idx,
  input  alu_op_t              i_op,
  input  reg_sel_t             i_dest,
  input  reg_sel_t             i_src1,
  input  reg_sel_t             i_src2,
  input  nibble_t              i_imm,
  input  logic                 i_dec,
  input  word_t                i_words [NUM_WREGS],
  output logic [NUM_WREGS-1:0] o_we,
  output nibble_t              o_wdata,
  output logic                 o_carry
);

  nibble_t        reg_nib [NUM_WREGS];
  nibble_t        src1_nib;
  nibble_t        src2_nib;
  logic           carry_q;
  logic           carry_in;
  logic [NIB_W:0] sum_raw;
  logic [NIB_W:0] diff_raw;
  nibble_t        add_nib;
  logic           add_cout;
  nibble_t        sub_nib;
  logic           sub_bout;
  nibble_t        res_nib;
  logic           res_carry;

  // nibble at the current index from every register
  always_comb begin
    for (int i = 0; i < NUM_WREGS; i++) begin
      reg_nib[i] = i_words[i][{i_idx, 2'b00} +: NIB_W];
    end
  end

  function automatic nibble_t pick_src(input reg_sel_t sel);
    nibble_t nib;
    nib = '0;
    if (sel == REG_IMM) begin
      nib = i_imm;
    end else if (sel < NUM_WREGS) begin
      nib = reg_nib[sel[1:0]];
    end
    return nib;
  endfunction

  assign src1_nib = pick_src(i_src1);
  assign src2_nib = pick_src(i_src2);

  // the ripple starts fresh on the first nibble of a field
  assign carry_in = i_first ? 1'b0 : carry_q;

  assign sum_raw  = {1'b0, src1_nib} + {1'b0, src2_nib} + {4'd0, carry_in};
  assign diff_raw = {1'b0, src1_nib} - {1'b0, src2_nib} - {4'd0, carry_in};

  always_comb begin
    add_nib  = sum_raw[NIB_W-1:0];
    add_cout = sum_raw[NIB_W];
    if (i_dec) begin
      add_cout = (sum_raw >= DEC_RADIX);
      if (add_cout) begin
        add_nib = nibble_t'(sum_raw - DEC_RADIX);
      end
    end
  end

  // a negative difference sets bit 4 in both modes
  always_comb begin
    sub_nib  = diff_raw[NIB_W-1:0];
    sub_bout = diff_raw[NIB_W];
    if (i_dec && sub_bout) begin
      sub_nib = diff_raw[NIB_W-1:0] + DEC_RADIX[NIB_W-1:0];
    end
  end

  always_comb begin
    case (i_op)
      OP_ZERO: begin
        res_nib   = '0;
        res_carry = 1'b0;
      end
      OP_COPY: begin
        res_nib   = src1_nib;
        res_carry = carry_q;
      end
      OP_ADD: begin
        res_nib   = add_nib;
        res_carry = add_cout;
      end
      default: begin
        res_nib   = sub_nib;
        res_carry = sub_bout;
      end
    endcase
  end

  // running carry doubles as the flag, so the last step leaves the final value
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      carry_q <= 1'b0;
    end else if (i_step) begin
      carry_q <= res_carry;
    end
  end

  // immediate as destination enables nothing
  always_comb begin
    o_we = '0;
    if (i_step && (i_dest < NUM_WREGS)) begin
      o_we[i_dest[1:0]] = 1'b1;
    end
  end

  assign o_wdata = res_nib;
  assign o_carry = carry_q;

endmodule

// ==== saturn_alu.sv ====
`timescale 1ns/100ps

module saturn_alu
  import saturn_alu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_start,
  input  alu_op_t  i_op,
  input  reg_sel_t i_dest,
  input  reg_sel_t i_src1,
  input  reg_sel_t i_src2,
  input  nib_idx_t i_field_start,
  input  nib_idx_t i_field_last,
  input  nibble_t  i_imm,
  input  logic     i_dec,
  input  reg_sel_t i_rd_sel,
  output word_t    o_rd_data,
  output logic     o_carry,
  output logic     o_busy,
  output logic     o_done
);

  logic                 step;
  logic                 first;
  nib_idx_t             step_idx;
  alu_op_t              op_q;
  reg_sel_t             dest_q;
  reg_sel_t             src1_q;
  reg_sel_t             src2_q;
  nibble_t              imm_q;
  logic                 dec_q;
  logic [NUM_WREGS-1:0] reg_we;
  nibble_t              wr_nib;
  word_t                reg_words [NUM_WREGS];

  alu_sequencer u_alu_sequencer (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_start       (i_start),
    .i_op          (i_op),
    .i_dest        (i_dest),
    .i_src1        (i_src1),
    .i_src2        (i_src2),
    .i_field_start (i_field_start),
    .i_field_last  (i_field_last),
    .i_imm         (i_imm),
    .i_dec         (i_dec),
    .o_step        (step),
    .o_first       (first),
    .o_idx         (step_idx),
    .o_op          (op_q),
    .o_dest        (dest_q),
    .o_src1        (src1_q),
    .o_src2        (src2_q),
    .o_imm         (imm_q),
    .o_dec         (dec_q),
    .o_busy        (o_busy),
    .o_done        (o_done)
  );

  // A, B, C, D
  for (genvar gi = 0; gi < NUM_WREGS; gi++) begin : g_wreg
    working_reg u_working_reg (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_we    (reg_we[gi]),
      .i_idx   (step_idx),
      .i_wdata (wr_nib),
      .o_word  (reg_words[gi])
    );
  end

  nibble_datapath u_nibble_datapath (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_step  (step),
    .i_first (first),
    .i_idx   (step_idx),
    .i_op    (op_q),
    .i_dest  (dest_q),
    .i_src1  (src1_q),
    .i_src2  (src2_q),
    .i_imm   (imm_q),
    .i_dec   (dec_q),
    .i_words (reg_words),
    .o_we    (reg_we),
    .o_wdata (wr_nib),
    .o_carry (o_carry)
  );

  // debug read port, immediate and unused codes read as zero
  always_comb begin
    o_rd_data = '0;
    if (i_rd_sel < NUM_WREGS) begin
      o_rd_data = reg_words[i_rd_sel[1:0]];
    end
  end

endmodule

// ==== saturn_alu_sva.sv ====
`timescale 1ns/100ps

module saturn_alu_sva
  import saturn_alu_pkg::*;
(
  input logic  i_clk,
  input logic  i_reset,
  input word_t i_rd_data,
  input logic  i_carry,
  input logic  i_busy,
  input logic  i_done,
  input logic  i_accept,
  input word_t i_exp_word,
  input logic  i_exp_carry,
  input int    i_exp_len
);

  logic err_flag = 1'b0;
  logic run_active;
  int   cyc;

  // cycles since the accepted strobe with 0 in the cycle right after it
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      run_active <= 1'b0;
      cyc        <= 0;
    end else if (i_accept) begin
      run_active <= 1'b1;
      cyc        <= 0;
    end else if (run_active) begin
      if (cyc == i_exp_len + 1) begin
        run_active <= 1'b0;
      end
      cyc <= cyc + 1;
    end
  end

  a_reset_flags: assert property (@(posedge i_clk)
    $past(i_reset) |-> !i_busy && !i_done && !i_carry)
    else begin
      $error("[FAIL] %0t: busy, done or carry set after reset", $time);
      err_flag = 1'b1;
    end

  a_reset_regs: assert property (@(posedge i_clk)
    i_reset && $past(i_reset) |-> i_rd_data == '0)
    else begin
      $error("[FAIL] %0t: register not cleared by reset", $time);
      err_flag = 1'b1;
    end

  a_busy_window: assert property (@(posedge i_clk) disable iff (i_reset)
    i_busy == (run_active && cyc >= 1 && cyc <= i_exp_len))
    else begin
      $error("[FAIL] %0t: busy outside its N-cycle window", $time);
      err_flag = 1'b1;
    end

  a_done_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
    i_done == (run_active && cyc == i_exp_len + 1))
    else begin
      $error("[FAIL] %0t: done not exactly N+1 cycles after strobe", $time);
      err_flag = 1'b1;
    end

  // flag settles at the last write edge
  a_carry_edge: assert property (@(posedge i_clk) disable iff (i_reset)
    run_active && cyc == i_exp_len |-> i_carry == i_exp_carry)
    else begin
      $error("[FAIL] %0t: carry flag not updated at last nibble", $time);
      err_flag = 1'b1;
    end

  a_result: assert property (@(posedge i_clk) disable iff (i_reset)
    i_done |-> i_rd_data == i_exp_word && i_carry == i_exp_carry)
    else begin
      $error("[FAIL] %0t: result word %h carry %b, expected %h carry %b", $time,
             $sampled(i_rd_data), $sampled(i_carry), $sampled(i_exp_word),
             $sampled(i_exp_carry));
      err_flag = 1'b1;
    end

endmodule

// ==== tb_saturn_alu.sv ====
`timescale 1ns/100ps

module tb_saturn_alu
  import saturn_alu_pkg::*;
();

  localparam int NUM_INSTR   = 9 + 32 + 2 + 40 + 30;
  localparam int CYCLE_LIMIT = NUM_INSTR * 20 + 100;

  logic     i_clk;
  logic     i_reset;
  logic     i_start;
  logic     i_dec;
  alu_op_t  i_op;
  reg_sel_t i_dest;
  reg_sel_t i_src1;
  reg_sel_t i_src2;
  reg_sel_t i_rd_sel;
  nib_idx_t i_field_start;
  nib_idx_t i_field_last;
  nibble_t  i_imm;
  word_t    o_rd_data;
  logic     o_carry;
  logic     o_busy;
  logic     o_done;

  // reference model state
  word_t m_words [NUM_WREGS];
  logic  m_carry;
  word_t exp_word;
  logic  exp_carry;
  int    exp_len;
  logic  start_ok;
  logic  err_seen;
  int    seed;
  int    cycle_count;

  saturn_alu u_saturn_alu (.*);

  bind saturn_alu saturn_alu_sva u_saturn_alu_sva (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_rd_data   (o_rd_data),
    .i_carry     (o_carry),
    .i_busy      (o_busy),
    .i_done      (o_done),
    .i_accept    (tb_saturn_alu.start_ok),
    .i_exp_word  (tb_saturn_alu.exp_word),
    .i_exp_carry (tb_saturn_alu.exp_carry),
    .i_exp_len   (tb_saturn_alu.exp_len)
  );

  assign err_seen = u_saturn_alu.u_saturn_alu_sva.err_flag;

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic int src_nibble(input reg_sel_t sel, input int idx, input nibble_t imm);
    if (sel == REG_IMM) begin
      return int'(imm);
    end
    return int'(m_words[sel[1:0]][idx*4 +: 4]);
  endfunction

  // walks the field nibble by nibble with a running carry or borrow
  task automatic apply_model(input alu_op_t op, input reg_sel_t dest, input reg_sel_t src1,
                             input reg_sel_t src2, input nib_idx_t fs, input int n,
                             input nibble_t imm, input logic dec);
    int idx;
    int a;
    int b;
    int r;
    int c;
    int radix;
    c = 0;
    radix = dec ? 10 : 16;
    for (int k = 0; k < n; k++) begin
      idx = (int'(fs) + k) % 16;
      a = src_nibble(src1, idx, imm);
      b = src_nibble(src2, idx, imm);
      case (op)
        OP_ZERO: r = 0;
        OP_COPY: r = a;
        OP_ADD: begin
          r = a + b + c;
          c = (r >= radix);
          r = r % radix;
        end
        default: begin
          r = a - b - c;
          c = (r < 0);
          if (c != 0) r = r + radix;
        end
      endcase
      if (dest < NUM_WREGS) m_words[dest[1:0]][idx*4 +: 4] = r[3:0];
    end
    if (op == OP_ZERO) m_carry = 1'b0;
    else if (op != OP_COPY) m_carry = c[0];
    exp_len   <= n;
    exp_carry <= m_carry;
    // register A stands in when the destination is the immediate
    exp_word  <= m_words[(dest < NUM_WREGS) ? dest[1:0] : REG_A[1:0]];
  endtask

  task automatic issue_instr(input alu_op_t op, input reg_sel_t dest, input reg_sel_t src1,
                             input reg_sel_t src2, input nib_idx_t fs, input nib_idx_t fl,
                             input nibble_t imm, input logic dec, input logic poke);
    int n;
    n = ((int'(fl) - int'(fs)) & 15) + 1;
    @(posedge i_clk);
    i_start       <= 1'b1;
    i_op          <= op;
    i_dest        <= dest;
    i_src1        <= src1;
    i_src2        <= src2;
    i_field_start <= fs;
    i_field_last  <= fl;
    i_imm         <= imm;
    i_dec         <= dec;
    i_rd_sel      <= (dest < NUM_WREGS) ? dest : REG_A;
    start_ok      <= 1'b1;
    apply_model(op, dest, src1, src2, fs, n, imm, dec);
    @(posedge i_clk);
    i_start  <= 1'b0;
    start_ok <= 1'b0;
    // second strobe lands while busy and must be dropped
    if (poke && n >= 3) begin
      repeat (2) @(posedge i_clk);
      i_start       <= 1'b1;
      i_op          <= alu_op_t'($random(seed));
      i_dest        <= reg_sel_t'({$random(seed)} % 4);
      i_field_start <= nib_idx_t'($random(seed));
      @(posedge i_clk);
      i_start <= 1'b0;
    end
    do @(negedge i_clk); while (!o_done);
  endtask

  initial begin
    cycle_count = 0;
    while (!err_seen && cycle_count < CYCLE_LIMIT) begin
      @(posedge i_clk);
      cycle_count++;
    end
    $display("Simulation FAILED");
    if (cycle_count >= CYCLE_LIMIT) begin
      $fatal(1, "timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
    end else begin
      $fatal(1, "[FAIL] %0t: an assertion check failed", $time);
    end
  end

  initial begin
    seed = 15;
    i_reset <= 1'b1;
    i_start <= 1'b0;
    i_op <= OP_ZERO;
    i_dest <= REG_A;
    i_src1 <= REG_A;
    i_src2 <= REG_A;
    i_field_start <= '0;
    i_field_last <= '0;
    i_imm <= '0;
    i_dec <= 1'b0;
    i_rd_sel <= REG_A;
    start_ok <= 1'b0;
    exp_word <= '0;
    exp_carry <= 1'b0;
    exp_len <= 0;
    m_words = '{default: '0};
    m_carry = 1'b0;
    // sweep the read port over all registers during reset
    for (int i = 0; i < 8; i++) begin
      @(posedge i_clk);
      i_rd_sel <= reg_sel_t'(i % 4);
    end
    i_reset <= 1'b0;

    issue_instr(OP_COPY, REG_A, REG_IMM, REG_A, 4'd0, 4'd15, 4'ha, 1'b0, 1'b0);
    issue_instr(OP_COPY, REG_B, REG_IMM, REG_A, 4'd2, 4'd5, 4'h3, 1'b0, 1'b0);
    issue_instr(OP_ZERO, REG_A, REG_A, REG_A, 4'd14, 4'd1, 4'h0, 1'b0, 1'b0);
    issue_instr(OP_COPY, REG_C, REG_A, REG_B, 4'd12, 4'd3, 4'h0, 1'b0, 1'b0);
    issue_instr(OP_ADD, REG_D, REG_A, REG_B, 4'd0, 4'd15, 4'h0, 1'b0, 1'b0);
    issue_instr(OP_SUB, REG_D, REG_B, REG_A, 4'd0, 4'd15, 4'h0, 1'b0, 1'b0);
    issue_instr(OP_COPY, REG_IMM, REG_A, REG_B, 4'd0, 4'd15, 4'h0, 1'b0, 1'b0);
    issue_instr(OP_ADD, REG_C, REG_C, REG_IMM, 4'd0, 4'd15, 4'hf, 1'b0, 1'b1);
    issue_instr(OP_ADD, REG_B, REG_B, REG_IMM, 4'd7, 4'd7, 4'h9, 1'b0, 1'b0);

    for (int i = 0; i < 40; i++) begin
      issue_instr(alu_op_t'($random(seed)), reg_sel_t'({$random(seed)} % 5),
                  reg_sel_t'({$random(seed)} % 5), reg_sel_t'({$random(seed)} % 5),
                  nib_idx_t'($random(seed)), nib_idx_t'($random(seed)),
                  nibble_t'($random(seed)), 1'b0, $random(seed) & 1);
    end

    // load valid decimal digits before the bcd runs
    for (int k = 0; k < 32; k++) begin
      issue_instr(OP_COPY, (k < 16) ? REG_A : REG_B, REG_IMM, REG_IMM, nib_idx_t'(k),
                  nib_idx_t'(k), nibble_t'({$random(seed)} % 10), 1'b0, 1'b0);
    end
    issue_instr(OP_ZERO, REG_C, REG_C, REG_C, 4'd0, 4'd15, 4'h0, 1'b0, 1'b0);
    issue_instr(OP_ZERO, REG_D, REG_D, REG_D, 4'd0, 4'd15, 4'h0, 1'b0, 1'b0);
    for (int i = 0; i < 30; i++) begin
      issue_instr(alu_op_t'(2 + {$random(seed)} % 2), reg_sel_t'({$random(seed)} % 4),
                  reg_sel_t'({$random(seed)} % 4), reg_sel_t'({$random(seed)} % 5),
                  nib_idx_t'($random(seed)), nib_idx_t'($random(seed)),
                  nibble_t'({$random(seed)} % 10), 1'b1, $random(seed) & 1);
    end

    repeat (3) @(negedge i_clk);
    if (err_seen) begin
      $display("Simulation FAILED");
      $fatal(1, "[FAIL] %0t: an assertion check failed", $time);
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
saturn_alu_pkg.sv
alu_sequencer.sv
working_reg.sv
nibble_datapath.sv
saturn_alu.sv
saturn_alu_sva.sv
tb_saturn_alu.sv
